/* project.f */
design/aprPkg.sv
design/aprCmdIf.sv
design/aprDecode.sv
design/aprFlags.sv
design/aprAcAddr.sv
design/aprDiagRead.sv
design/aprTop.sv
verification/aprClockGen.sv
verification/aprProps.sv
verification/aprTb.sv

/* verification/aprTb.sv */
`timescale 1ns/10ps
`default_nettype none

module aprTb;

  logic clk;
  logic arstN;
  aprPkg::aprCondE cond;
  logic [aprPkg::magicWidth-1:0] magic;
  logic [aprPkg::wordWidth-1:0] ebusData;
  logic [aprPkg::flagCount-1:0] events;
  aprPkg::fmSelE fmSel;
  logic [aprPkg::fmAdrWidth-1:0] ac;
  logic [aprPkg::fmAdrWidth-1:0] xr;
  logic [aprPkg::fmAdrWidth-1:0] vma;
  logic xrPrevious;
  logic aprInterrupt;
  logic [aprPkg::flagCount-1:0] flags;
  logic [aprPkg::fmAdrWidth-1:0] fmAdr;
  logic [aprPkg::blockWidth-1:0] fmBlock;
  logic [aprPkg::wordWidth-1:0] diagData;
  logic diagValid;

  // Reference model state
  logic [aprPkg::flagCount-1:0] mFlags;
  logic [aprPkg::flagCount-1:0] mEnables;
  logic [aprPkg::blockWidth-1:0] mCurBlock;
  logic [aprPkg::blockWidth-1:0] mPrevBlock;
  logic [aprPkg::wordWidth-1:0] expDiagWord;
  logic expDiagValid;

  int errors = 0;
  int checks = 0;
  integer seed;

  aprClockGen aprClockGen_inst (
    .clk   (clk),
    .arstN (arstN)
  );

  aprTop aprTop_inst (
    .clk          (clk),
    .arstN        (arstN),
    .cond         (cond),
    .magic        (magic),
    .ebusData     (ebusData),
    .events       (events),
    .fmSel        (fmSel),
    .ac           (ac),
    .xr           (xr),
    .vma          (vma),
    .xrPrevious   (xrPrevious),
    .aprInterrupt (aprInterrupt),
    .flags        (flags),
    .fmAdr        (fmAdr),
    .fmBlock      (fmBlock),
    .diagData     (diagData),
    .diagValid    (diagValid)
  );

  bind aprTop aprProps aprProps_inst (
    .clk          (clk),
    .arstN        (arstN),
    .cond         (cond),
    .events       (events),
    .flags        (flags),
    .aprInterrupt (aprInterrupt),
    .diagValid    (diagValid)
  );

  function automatic logic [3:0] expectFmAdr(input aprPkg::fmSelE sel,
      input logic [3:0] a, input logic [3:0] x, input logic [3:0] v,
      input logic [8:0] mg);
    case (sel)
      aprPkg::selAc:          return a;
      aprPkg::selAcPlus1:     return (a + 1) % 16;
      aprPkg::selXr:          return x;
      aprPkg::selVma:         return v;
      aprPkg::selAcPlus2:     return (a + 2) % 16;
      aprPkg::selAcPlus3:     return (a + 3) % 16;
      aprPkg::selAcPlusMagic: return (a + mg[8:5]) % 16;
      default:                return mg[8:5];
    endcase
  endfunction

  function automatic logic [2:0] expectFmBlock(input aprPkg::fmSelE sel,
      input logic xp, input logic [2:0] cur, input logic [2:0] prev,
      input logic [8:0] mg);
    if (sel == aprPkg::selMagic) begin
      return mg[4:2];
    end
    if (sel == aprPkg::selXr && xp) begin
      return prev;
    end
    return cur;
  endfunction

  function automatic logic [35:0] expectDiagWord(input aprPkg::diagFuncE func,
      input logic [7:0] fl, input logic [7:0] en, input logic [2:0] cur,
      input logic [2:0] prev, input logic [3:0] fa, input logic [2:0] fb);
    logic [35:0] w;
    w = '0;
    case (func)
      aprPkg::diagFlags:   w[13:6] = fl;
      aprPkg::diagEnables: w[13:6] = en;
      aprPkg::diagBlocks: begin
        w[8:6] = cur;
        w[11:9] = prev;
      end
      default: begin
        w[8:6] = fb;
        w[12:9] = fa;
      end
    endcase
    return w;
  endfunction

  always @(posedge clk or negedge arstN) begin : refModel
    logic [7:0] nextFlags;
    logic [7:0] nextEnables;
    logic [7:0] mask;
    mask = ebusData[13:6];
    nextFlags = mFlags;
    nextEnables = mEnables;
    if (!arstN) begin
      mFlags <= '0;
      mEnables <= '0;
      mCurBlock <= '0;
      mPrevBlock <= '0;
      expDiagWord <= '0;
      expDiagValid <= 1'b0;
    end else begin
      for (int i = 0; i < aprPkg::flagCount; i++) begin
        if (events[i] || (cond == aprPkg::condSetFlags && mask[i])) begin
          nextFlags[i] = 1'b1;
        end else if (cond == aprPkg::condClrFlags && mask[i]) begin
          nextFlags[i] = 1'b0;
        end
        if (cond == aprPkg::condSetEnables && mask[i]) begin
          nextEnables[i] = 1'b1;
        end else if (cond == aprPkg::condClrEnables && mask[i]) begin
          nextEnables[i] = 1'b0;
        end
      end
      if (cond == aprPkg::condLoadBlocks) begin
        mCurBlock <= ebusData[8:6];
        mPrevBlock <= ebusData[11:9];
      end
      if (cond == aprPkg::condDiagRead) begin
        expDiagWord <= expectDiagWord(aprPkg::diagFuncE'(magic[1:0]), mFlags,
          mEnables, mCurBlock, mPrevBlock, expectFmAdr(fmSel, ac, xr, vma, magic),
          expectFmBlock(fmSel, xrPrevious, mCurBlock, mPrevBlock, magic));
      end
      expDiagValid <= (cond == aprPkg::condDiagRead);
      mFlags <= nextFlags;
      mEnables <= nextEnables;
    end
  end

  task automatic reportMismatch(input string name, input logic [35:0] got,
      input logic [35:0] exp);
    errors++;
    $display("FAIL %s: got 0x%0h, expected 0x%0h at %0t ns", name, got, exp, $time);
  endtask

  // Outputs compared mid-cycle, away from the drive edge
  always @(negedge clk) begin : outputCheck
    checks++;
    assert (flags === mFlags) else reportMismatch("flags", flags, mFlags);
    assert (aprInterrupt === |(mFlags & mEnables))
      else reportMismatch("aprInterrupt", aprInterrupt, |(mFlags & mEnables));
    assert (fmAdr === expectFmAdr(fmSel, ac, xr, vma, magic))
      else reportMismatch("fmAdr", fmAdr, expectFmAdr(fmSel, ac, xr, vma, magic));
    assert (fmBlock === expectFmBlock(fmSel, xrPrevious, mCurBlock, mPrevBlock, magic))
      else reportMismatch("fmBlock", fmBlock,
        expectFmBlock(fmSel, xrPrevious, mCurBlock, mPrevBlock, magic));
    assert (diagValid === expDiagValid)
      else reportMismatch("diagValid", diagValid, expDiagValid);
    if (expDiagValid) begin
      assert (diagData === expDiagWord)
        else reportMismatch("diagData", diagData, expDiagWord);
    end
  end

  task automatic abortOnTimeout(input string what);
    $display("Timeout: no %s within the cycle limit", what);
    $display("** FAIL **");
    $finish;
  endtask

  task automatic nextCycle;
    @(posedge clk);
    #2;
  endtask

  task automatic issueCond(input aprPkg::aprCondE c, input logic [7:0] mask,
      input logic [8:0] mg, input logic [7:0] ev);
    cond = c;
    ebusData = {22'h0, mask, 6'h0};
    magic = mg;
    events = ev;
    nextCycle();
    cond = aprPkg::condNone;
    events = '0;
  endtask

  task automatic waitForReset;
    int n;
    n = 0;
    while (arstN !== 1'b1 && n < 20) begin
      @(posedge clk);
      n++;
    end
    if (arstN !== 1'b1) begin
      abortOnTimeout("reset release");
    end
  endtask

  task automatic readDiag(input aprPkg::diagFuncE func, input logic [6:0] mgHigh);
    int n;
    n = 0;
    issueCond(aprPkg::condDiagRead, 8'h00, {mgHigh, func}, 8'h00);
    while (diagValid !== 1'b1 && n < 8) begin
      nextCycle();
      n++;
    end
    if (diagValid !== 1'b1) begin
      abortOnTimeout("diagValid after a diagnostic read");
    end
  endtask

  initial begin : stimulus
    logic [31:0] rnd;
    seed = 65817;
    cond = aprPkg::condNone;
    magic = '0;
    ebusData = '0;
    events = '0;
    fmSel = aprPkg::selAc;
    ac = '0;
    xr = '0;
    vma = '0;
    xrPrevious = 1'b0;
    waitForReset();
    nextCycle();

    // Flags from events, masked set and clear, event beating a clear
    for (int i = 0; i < aprPkg::flagCount; i++) begin
      issueCond(aprPkg::condNone, 8'h00, 9'h000, 8'h01 << i);
    end
    issueCond(aprPkg::condClrFlags, 8'hff, 9'h000, 8'h08);
    issueCond(aprPkg::condClrFlags, 8'h08, 9'h000, 8'h00);
    issueCond(aprPkg::condSetFlags, 8'ha5, 9'h000, 8'h00);
    issueCond(aprPkg::condClrFlags, 8'h0f, 9'h000, 8'h00);

    // Interrupt enables
    issueCond(aprPkg::condSetEnables, 8'hf0, 9'h000, 8'h00);
    issueCond(aprPkg::condNone, 8'h00, 9'h000, 8'h40);
    issueCond(aprPkg::condClrEnables, 8'hb0, 9'h000, 8'h00);
    issueCond(aprPkg::condClrFlags, 8'hff, 9'h000, 8'h00);
    issueCond(aprPkg::condSetEnables, 8'h03, 9'h000, 8'h00);
    issueCond(aprPkg::condNone, 8'h00, 9'h000, 8'h02);

    // Every address select with both xrPrevious values
    issueCond(aprPkg::condLoadBlocks, {2'b00, 3'd2, 3'd5}, 9'h000, 8'h00);
    for (int s = 0; s < 8; s++) begin
      fmSel = aprPkg::fmSelE'(s);
      ac = 4'he;
      xr = 4'h3;
      vma = 4'h9;
      magic = 9'h1b5;
      xrPrevious = 1'b0;
      nextCycle();
      xrPrevious = 1'b1;
      nextCycle();
    end

    readDiag(aprPkg::diagFlags, 7'h00);
    readDiag(aprPkg::diagEnables, 7'h00);
    readDiag(aprPkg::diagBlocks, 7'h00);
    readDiag(aprPkg::diagFmAdr, 7'h5a);

    for (int c = 0; c < 300; c++) begin
      rnd = $random(seed);
      ebusData[31:0] = rnd;
      rnd = $random(seed);
      ebusData[35:32] = rnd[3:0];
      magic = rnd[12:4];
      fmSel = aprPkg::fmSelE'(rnd[15:13]);
      ac = rnd[19:16];
      xr = rnd[23:20];
      vma = rnd[27:24];
      xrPrevious = rnd[28];
      rnd = $random(seed);
      cond = aprPkg::aprCondE'(rnd[2:0]);
      events = rnd[10:3] & rnd[18:11] & rnd[26:19];
      nextCycle();
    end
    cond = aprPkg::condNone;
    events = '0;
    nextCycle();
    nextCycle();

    $display("Checked %0d cycles, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verification/aprProps.sv */
`timescale 1ns/10ps
`default_nettype none

module aprProps (
  input wire                          clk,
  input wire                          arstN,
  input wire aprPkg::aprCondE         cond,
  input wire [aprPkg::flagCount-1:0]  events,
  input wire [aprPkg::flagCount-1:0]  flags,
  input wire                          aprInterrupt,
  input wire                          diagValid
);

  // Read strobe gives a valid word on the next cycle
  diagValidAfterRead: assert property (@(posedge clk) disable iff (!arstN)
    (cond == aprPkg::condDiagRead) |=> diagValid)
    else $error("diagValid missing one cycle after a diagnostic read");

  // No valid word without a read strobe
  diagValidOnlyAfterRead: assert property (@(posedge clk) disable iff (!arstN)
    (cond != aprPkg::condDiagRead) |=> !diagValid)
    else $error("diagValid high without a preceding diagnostic read");

  // Event always lands in its flag
  eventSetsFlag: assert property (@(posedge clk) disable iff (!arstN)
    (events != '0) |=> ((flags & $past(events)) == $past(events)))
    else $error("an event pulse did not set its flag");

  // Interrupt only drops after a flag or enable clear
  interruptHeldUntilClear: assert property (@(posedge clk) disable iff (!arstN)
    (aprInterrupt && cond != aprPkg::condClrFlags && cond != aprPkg::condClrEnables)
    |=> aprInterrupt)
    else $error("interrupt dropped without a flag or enable clear");

endmodule

`default_nettype wire

/* verification/aprClockGen.sv */
`timescale 1ns/10ps
`default_nettype none

module aprClockGen (
  output logic clk,
  output logic arstN
);

  // 20 ns period
  initial begin
    clk = 1'b0;
    forever begin
      #10;
      clk = ~clk;
    end
  end

  // Reset low for 8 rising edges, released just after the edge
  initial begin
    arstN = 1'b0;
    repeat (8) @(posedge clk);
    #2;
    arstN = 1'b1;
  end

endmodule

`default_nettype wire

/* design/aprTop.sv */
`timescale 1ns/10ps
`default_nettype none

module aprTop (
  input  wire                           clk,
  input  wire                           arstN,
  input  wire aprPkg::aprCondE          cond,
  input  wire [aprPkg::magicWidth-1:0]  magic,
  input  wire [aprPkg::wordWidth-1:0]   ebusData,
  input  wire [aprPkg::flagCount-1:0]   events,
  input  wire aprPkg::fmSelE            fmSel,
  input  wire [aprPkg::fmAdrWidth-1:0]  ac,
  input  wire [aprPkg::fmAdrWidth-1:0]  xr,
  input  wire [aprPkg::fmAdrWidth-1:0]  vma,
  input  wire                           xrPrevious,
  output logic                          aprInterrupt,
  output logic [aprPkg::flagCount-1:0]  flags,
  output logic [aprPkg::fmAdrWidth-1:0] fmAdr,
  output logic [aprPkg::blockWidth-1:0] fmBlock,
  output logic [aprPkg::wordWidth-1:0]  diagData,
  output logic                          diagValid
);

  logic [aprPkg::flagCount-1:0] enables;
  logic [aprPkg::blockWidth-1:0] curBlock;
  logic [aprPkg::blockWidth-1:0] prevBlock;

  aprCmdIf cmdIf ();

  aprDecode aprDecode_inst (
    .cond     (cond),
    .magic    (magic),
    .ebusData (ebusData),
    .cmd      (cmdIf.decode)
  );

  aprFlags aprFlags_inst (
    .clk       (clk),
    .arstN     (arstN),
    .cmd       (cmdIf.exec),
    .events    (events),
    .flags     (flags),
    .enables   (enables),
    .interrupt (aprInterrupt)
  );

  aprAcAddr aprAcAddr_inst (
    .clk        (clk),
    .arstN      (arstN),
    .cmd        (cmdIf.exec),
    .fmSel      (fmSel),
    .ac         (ac),
    .xr         (xr),
    .vma        (vma),
    .magic      (magic),
    .xrPrevious (xrPrevious),
    .curBlock   (curBlock),
    .prevBlock  (prevBlock),
    .fmAdr      (fmAdr),
    .fmBlock    (fmBlock)
  );

  aprDiagRead aprDiagRead_inst (
    .clk       (clk),
    .arstN     (arstN),
    .cmd       (cmdIf.exec),
    .flags     (flags),
    .enables   (enables),
    .curBlock  (curBlock),
    .prevBlock (prevBlock),
    .fmAdr     (fmAdr),
    .fmBlock   (fmBlock),
    .diagData  (diagData),
    .diagValid (diagValid)
  );

endmodule

`default_nettype wire

/* design/aprDiagRead.sv */
`timescale 1ns/10ps
`default_nettype none

module aprDiagRead (
  input  wire                           clk,
  input  wire                           arstN,
  aprCmdIf.exec                         cmd,
  input  wire [aprPkg::flagCount-1:0]   flags,
  input  wire [aprPkg::flagCount-1:0]   enables,
  input  wire [aprPkg::blockWidth-1:0]  curBlock,
  input  wire [aprPkg::blockWidth-1:0]  prevBlock,
  input  wire [aprPkg::fmAdrWidth-1:0]  fmAdr,
  input  wire [aprPkg::blockWidth-1:0]  fmBlock,
  output logic [aprPkg::wordWidth-1:0]  diagData,
  output logic                          diagValid
);

  localparam int hiField = aprPkg::flagLsb + aprPkg::blockWidth;

  logic [aprPkg::wordWidth-1:0] diagWord;

  always_comb begin
    diagWord = '0;
    case (cmd.diagFunc)
      aprPkg::diagFlags: begin
        diagWord[aprPkg::flagLsb +: aprPkg::flagCount] = flags;
      end
      aprPkg::diagEnables: begin
        diagWord[aprPkg::flagLsb +: aprPkg::flagCount] = enables;
      end
      aprPkg::diagBlocks: begin
        diagWord[aprPkg::flagLsb +: aprPkg::blockWidth] = curBlock;
        diagWord[hiField +: aprPkg::blockWidth] = prevBlock;
      end
      default: begin
        diagWord[aprPkg::flagLsb +: aprPkg::blockWidth] = fmBlock;
        diagWord[hiField +: aprPkg::fmAdrWidth] = fmAdr;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (cmd.diagRead) begin
      diagData <= diagWord;
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      diagValid <= 1'b0;
    end else begin
      diagValid <= cmd.diagRead;
    end
  end

endmodule

`default_nettype wire

/* design/aprAcAddr.sv */
`timescale 1ns/10ps
`default_nettype none

module aprAcAddr (
  input  wire                           clk,
  input  wire                           arstN,
  aprCmdIf.exec                         cmd,
  input  wire aprPkg::fmSelE            fmSel,
  input  wire [aprPkg::fmAdrWidth-1:0]  ac,
  input  wire [aprPkg::fmAdrWidth-1:0]  xr,
  input  wire [aprPkg::fmAdrWidth-1:0]  vma,
  input  wire [aprPkg::magicWidth-1:0]  magic,
  input  wire                           xrPrevious,
  output logic [aprPkg::blockWidth-1:0] curBlock,
  output logic [aprPkg::blockWidth-1:0] prevBlock,
  output logic [aprPkg::fmAdrWidth-1:0] fmAdr,
  output logic [aprPkg::blockWidth-1:0] fmBlock
);

  logic [aprPkg::fmAdrWidth-1:0] magicAdr;
  logic [aprPkg::blockWidth-1:0] magicBlock;
  logic [aprPkg::fmAdrWidth-1:0] acPlus1;
  logic [aprPkg::fmAdrWidth-1:0] acPlus2;
  logic [aprPkg::fmAdrWidth-1:0] acPlus3;
  logic [aprPkg::fmAdrWidth-1:0] acPlusMagic;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      curBlock <= '0;
      prevBlock <= '0;
    end else if (cmd.loadBlocks) begin
      curBlock <= cmd.curBlockIn;
      prevBlock <= cmd.prevBlockIn;
    end
  end

  // Magic bits 5-8 give an AC offset, bits 2-4 a block
  always_comb begin
    magicAdr = magic[8:5];
    magicBlock = magic[4:2];
  end

  // Sums wrap within the 16 word block
  always_comb begin
    acPlus1 = ac + aprPkg::fmAdrWidth'(1);
    acPlus2 = ac + aprPkg::fmAdrWidth'(2);
    acPlus3 = ac + aprPkg::fmAdrWidth'(3);
    acPlusMagic = ac + magicAdr;
  end

  always_comb begin
    case (fmSel)
      aprPkg::selAc:          fmAdr = ac;
      aprPkg::selAcPlus1:     fmAdr = acPlus1;
      aprPkg::selXr:          fmAdr = xr;
      aprPkg::selVma:         fmAdr = vma;
      aprPkg::selAcPlus2:     fmAdr = acPlus2;
      aprPkg::selAcPlus3:     fmAdr = acPlus3;
      aprPkg::selAcPlusMagic: fmAdr = acPlusMagic;
      default:                fmAdr = magicAdr;
    endcase
  end

  // Index register may live in the previous context
  always_comb begin
    if (fmSel == aprPkg::selMagic) begin
      fmBlock = magicBlock;
    end else if (fmSel == aprPkg::selXr && xrPrevious) begin
      fmBlock = prevBlock;
    end else begin
      fmBlock = curBlock;
    end
  end

endmodule

`default_nettype wire

/* design/aprFlags.sv */
`timescale 1ns/10ps
`default_nettype none

module aprFlags (
  input  wire                          clk,
  input  wire                          arstN,
  aprCmdIf.exec                        cmd,
  input  wire [aprPkg::flagCount-1:0]  events,
  output logic [aprPkg::flagCount-1:0] flags,
  output logic [aprPkg::flagCount-1:0] enables,
  output logic                         interrupt
);

  logic [aprPkg::flagCount-1:0] flagSet;
  logic [aprPkg::flagCount-1:0] flagClr;
  logic [aprPkg::flagCount-1:0] enSet;
  logic [aprPkg::flagCount-1:0] enClr;
  logic [aprPkg::flagCount-1:0] flagsNext;
  logic [aprPkg::flagCount-1:0] enablesNext;

  always_comb begin
    flagSet = cmd.setFlags ? cmd.mask : '0;
    flagClr = cmd.clrFlags ? cmd.mask : '0;
    enSet = cmd.setEnables ? cmd.mask : '0;
    enClr = cmd.clrEnables ? cmd.mask : '0;
  end

  // Event pulse overrides a clear of the same flag
  always_comb begin
    flagsNext = ((flags | flagSet) & ~flagClr) | events;
    enablesNext = (enables | enSet) & ~enClr;
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      flags <= '0;
      enables <= '0;
    end else begin
      flags <= flagsNext;
      enables <= enablesNext;
    end
  end

  // Any enabled flag requests the interrupt
  always_comb begin
    interrupt = |(flags & enables);
  end

endmodule

`default_nettype wire

/* design/aprDecode.sv */
`timescale 1ns/10ps
`default_nettype none

module aprDecode (
  input  wire aprPkg::aprCondE          cond,
  input  wire [aprPkg::magicWidth-1:0] magic,
  input  wire [aprPkg::wordWidth-1:0]  ebusData,
  aprCmdIf.decode                      cmd
);

  // One strobe per condition, nothing for condNone or spare codes
  always_comb begin
    cmd.setFlags = 1'b0;
    cmd.clrFlags = 1'b0;
    cmd.setEnables = 1'b0;
    cmd.clrEnables = 1'b0;
    cmd.loadBlocks = 1'b0;
    cmd.diagRead = 1'b0;
    case (cond)
      aprPkg::condSetFlags: begin
        cmd.setFlags = 1'b1;
      end
      aprPkg::condClrFlags: begin
        cmd.clrFlags = 1'b1;
      end
      aprPkg::condSetEnables: begin
        cmd.setEnables = 1'b1;
      end
      aprPkg::condClrEnables: begin
        cmd.clrEnables = 1'b1;
      end
      aprPkg::condLoadBlocks: begin
        cmd.loadBlocks = 1'b1;
      end
      aprPkg::condDiagRead: begin
        cmd.diagRead = 1'b1;
      end
      default: begin
      end
    endcase
  end

  // Data fields straight from the bus word
  always_comb begin
    cmd.mask = ebusData[aprPkg::flagLsb +: aprPkg::flagCount];
    cmd.curBlockIn = ebusData[aprPkg::flagLsb +: aprPkg::blockWidth];
    cmd.prevBlockIn =
      ebusData[aprPkg::flagLsb + aprPkg::blockWidth +: aprPkg::blockWidth];
  end

  // Readback function select in magic bits 0 and 1
  always_comb begin
    cmd.diagFunc = aprPkg::diagFuncE'(magic[1:0]);
  end

endmodule

`default_nettype wire

/* design/aprCmdIf.sv */
`timescale 1ns/10ps
`default_nettype none

interface aprCmdIf;

  logic setFlags;
  logic clrFlags;
  logic setEnables;
  logic clrEnables;
  logic loadBlocks;
  logic diagRead;
  logic [aprPkg::flagCount-1:0] mask;
  logic [aprPkg::blockWidth-1:0] curBlockIn;
  logic [aprPkg::blockWidth-1:0] prevBlockIn;
  aprPkg::diagFuncE diagFunc;

  modport decode (
    output setFlags, clrFlags, setEnables, clrEnables, loadBlocks, diagRead,
    output mask, curBlockIn, prevBlockIn, diagFunc
  );

  modport exec (
    input setFlags, clrFlags, setEnables, clrEnables, loadBlocks, diagRead,
    input mask, curBlockIn, prevBlockIn, diagFunc
  );

endinterface

`default_nettype wire

/* design/aprPkg.sv */
`default_nettype none

package aprPkg;

  localparam int wordWidth = 36;

  // Flag order is sbusErr, nxmErr, ioPageFail, mbParErr,
  // cacheDirParErr, sbusAdrParErr, powerFail, sweepDone
  localparam int flagCount = 8;
  localparam int flagLsb = 6;

  localparam int magicWidth = 9;
  localparam int fmAdrWidth = 4;
  localparam int blockWidth = 3;

  // Microcode condition codes
  typedef enum logic [2:0] {
    condNone       = 3'd0,
    condSetFlags   = 3'd1,
    condClrFlags   = 3'd2,
    condSetEnables = 3'd3,
    condClrEnables = 3'd4,
    condLoadBlocks = 3'd5,
    condDiagRead   = 3'd6
  } aprCondE;

  // Fast-memory address select from the microcode FMADR field
  typedef enum logic [2:0] {
    selAc          = 3'd0,
    selAcPlus1     = 3'd1,
    selXr          = 3'd2,
    selVma         = 3'd3,
    selAcPlus2     = 3'd4,
    selAcPlus3     = 3'd5,
    selAcPlusMagic = 3'd6,
    selMagic       = 3'd7
  } fmSelE;

  typedef enum logic [1:0] {
    diagFlags   = 2'd0,
    diagEnables = 2'd1,
    diagBlocks  = 2'd2,
    diagFmAdr   = 2'd3
  } diagFuncE;

endpackage

`default_nettype wire
